//--- tb.f
src/vga_text_pkg.sv
src/vga_timing.sv
src/ps2_receiver.sv
src/key_writer.sv
src/glyph_renderer.sv
src/vga_text_top.sv
tb/tb_vga_text.sv

//--- Bender.yml
package:
  name: vga_text

sources:
  - src/vga_text_pkg.sv
  - src/vga_timing.sv
  - src/ps2_receiver.sv
  - src/key_writer.sv
  - src/glyph_renderer.sv
  - src/vga_text_top.sv
  - target: test
    files:
      - tb/tb_vga_text.sv

//--- tb/tb_vga_text.sv
`timescale 1ns/100ps

module tb_vga_text;

	localparam vga_text_pkg::rgb_t fg = '{r: 8'hf0, g: 8'hc8, b: 8'h30};
	localparam vga_text_pkg::rgb_t bg = '{r: 8'h10, g: 8'h24, b: 8'h48};
	localparam int sel_hsync    = 0;
	localparam int sel_vsync    = 1;
	localparam int sel_blank    = 2;
	localparam int frame_cycles = 420000;

	logic                      clk;
	logic                      arst_n;
	logic                      ps2_clk;
	logic                      ps2_data;
	vga_text_pkg::font_write_t font_wr;
	logic                      hsync;
	logic                      vsync;
	logic                      blank_n;
	vga_text_pkg::rgb_t        rgb;
	logic                      frame_error;

	// reference state for font and screen
	logic [31:0] rng_state;
	logic [7:0]  font_model [vga_text_pkg::font_glyphs][vga_text_pkg::cell_h];
	logic [7:0]  screen [vga_text_pkg::text_rows][vga_text_pkg::text_cols];
	int          cur_col;
	int          cur_row;
	logic        brk_seen;
	logic        ext_seen;

	vga_text_top #(
		.fg_color (fg),
		.bg_color (bg)
	) dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.font_wr     (font_wr),
		.hsync       (hsync),
		.vsync       (vsync),
		.blank_n     (blank_n),
		.rgb         (rgb),
		.frame_error (frame_error)
	);

	always #4 clk = ~clk;

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_rgb(input string name, input vga_text_pkg::rgb_t exp,
			input vga_text_pkg::rgb_t act);
		if (act !== exp) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("Error %s: expected %0d, actual %0d", name, exp, act);
			abort_run();
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic probe(input int sel);
		case (sel)
			sel_hsync: return hsync;
			sel_vsync: return vsync;
			default:   return blank_n;
		endcase
	endfunction

	function automatic string sig_name(input int sel);
		case (sel)
			sel_hsync: return "hsync";
			sel_vsync: return "vsync";
			default:   return "blank_n";
		endcase
	endfunction

	// counts falling clock edges until the signal shows the level
	task automatic cycles_until(input int sel, input logic level, input int limit, output int n);
		@(negedge clk);
		n = 1;
		while (probe(sel) !== level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (probe(sel) !== level) begin
			$display("timeout: %s did not reach %b within %0d cycles", sig_name(sel), level, limit);
			abort_run();
		end
	endtask

	// make codes known to the reference model
	function automatic logic [7:0] key_ascii(input logic [7:0] code);
		case (code)
			8'h1c:   return "a";
			8'h32:   return "b";
			8'h21:   return "c";
			8'h23:   return "d";
			8'h24:   return "e";
			8'h16:   return "1";
			8'h29:   return " ";
			default: return 8'h00;
		endcase
	endfunction

	task automatic model_key(input logic [7:0] code);
		logic [7:0] ch;
		ch = key_ascii(code);
		if (code == 8'hf0) begin
			brk_seen = 1'b1;
		end else if (code == 8'he0) begin
			ext_seen = 1'b1;
		end else if (brk_seen || ext_seen) begin
			brk_seen = 1'b0;
			ext_seen = 1'b0;
		end else if (code == 8'h5a) begin
			cur_col = 0;
			cur_row = (cur_row + 1) % vga_text_pkg::text_rows;
		end else if (code == 8'h66) begin
			if (cur_col != 0 || cur_row != 0) begin
				if (cur_col == 0) begin
					cur_col = vga_text_pkg::text_cols - 1;
					cur_row = cur_row - 1;
				end else begin
					cur_col = cur_col - 1;
				end
				screen[cur_row][cur_col] = " ";
			end
		end else if (ch != 8'h00) begin
			screen[cur_row][cur_col] = ch;
			cur_col = cur_col + 1;
			if (cur_col == vga_text_pkg::text_cols) begin
				cur_col = 0;
				cur_row = (cur_row + 1) % vga_text_pkg::text_rows;
			end
		end
	endtask

	// one PS/2 frame at 40 clk per bit with data changing while ps2_clk is high
	task automatic type_key(input string name, input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		logic        parity;
		logic        seen_valid;
		logic        seen_err;
		int          n;
		parity = ~^code;
		if (bad_parity) begin
			parity = ~parity;
		end
		frame = {1'b1, parity, code, 1'b0};
		seen_valid = 1'b0;
		seen_err = 1'b0;
		@(posedge clk);
		for (int i = 0; i < 11; i++) begin
			ps2_data <= frame[i];
			repeat (20) @(posedge clk);
			ps2_clk <= 1'b0;
			if (i < 10) begin
				repeat (20) @(posedge clk);
				ps2_clk <= 1'b1;
			end
		end
		n = 0;
		while (!seen_valid && !seen_err && n < 12) begin
			@(negedge clk);
			n++;
			seen_valid = dut.code_valid;
			seen_err = frame_error;
		end
		if (!seen_valid && !seen_err) begin
			$display("timeout: receiver gave no result for scan code %h in %s", code, name);
			abort_run();
		end
		check_bit({name, " code_valid"}, !bad_parity, seen_valid);
		check_bit({name, " frame_error"}, bad_parity, seen_err);
		@(negedge clk);
		check_bit({name, " strobe width"}, 1'b0, dut.code_valid | frame_error);
		if (!bad_parity) begin
			model_key(code);
		end
		@(posedge clk);
		ps2_clk <= 1'b1;
		ps2_data <= 1'b1;
		repeat (40) @(posedge clk);
	endtask

	task automatic load_font();
		for (int g = 0; g < vga_text_pkg::font_glyphs; g++) begin
			for (int l = 0; l < vga_text_pkg::cell_h; l++) begin
				rng_state = xorshift(rng_state);
				font_model[g][l] = rng_state[7:0];
				@(posedge clk);
				font_wr <= '{valid: 1'b1, code: 7'(g), line: 4'(l), bits: rng_state[7:0]};
			end
		end
		@(posedge clk);
		font_wr <= '0;
	endtask

	function automatic vga_text_pkg::rgb_t expected_pixel(input int x, input int y);
		int         col;
		int         cx;
		int         row;
		int         cy;
		logic [7:0] bits;
		col = x / 9;
		cx = x % 9;
		row = y / 16;
		cy = y % 16;
		// blank ninth column and the strip right of column 69
		if (col >= 70 || cx == 8) begin
			return bg;
		end
		bits = font_model[screen[row][col][6:0]][cy];
		return bits[7 - cx] ? fg : bg;
	endfunction

	task automatic compare_frame(input string name);
		int n;
		cycles_until(sel_vsync, 1'b0, frame_cycles + 1000, n);
		cycles_until(sel_vsync, 1'b1, 2000, n);
		for (int y = 0; y < 480; y++) begin
			cycles_until(sel_blank, 1'b1, (y == 0) ? 30000 : 200, n);
			for (int x = 0; x < 640; x++) begin
				check_rgb(name, expected_pixel(x, y), rgb);
				@(negedge clk);
			end
			check_bit({name, " blank_n after line"}, 1'b0, blank_n);
		end
	endtask

	task automatic test_raster();
		int low;
		int high;
		int n;
		cycles_until(sel_hsync, 1'b1, 1000, n);
		cycles_until(sel_hsync, 1'b0, 1000, n);
		for (int i = 0; i < 3; i++) begin
			cycles_until(sel_hsync, 1'b1, 1000, low);
			cycles_until(sel_hsync, 1'b0, 1000, high);
			check_count("raster hsync low", 96, low);
			check_count("raster hsync period", 800, low + high);
		end
		cycles_until(sel_vsync, 1'b1, frame_cycles, n);
		cycles_until(sel_vsync, 1'b0, frame_cycles + 1000, n);
		cycles_until(sel_vsync, 1'b1, 2000, low);
		cycles_until(sel_vsync, 1'b0, frame_cycles, high);
		check_count("raster vsync low", 1600, low);
		check_count("raster vsync period", 420000, low + high);
		// first visible line after the back porch
		cycles_until(sel_blank, 1'b1, 30000, n);
		for (int i = 0; i < 3; i++) begin
			cycles_until(sel_blank, 1'b0, 1000, high);
			cycles_until(sel_blank, 1'b1, 1000, low);
			check_count("raster blank_n high", 640, high);
			check_count("raster blank_n low", 160, low);
		end
	endtask

	// every cell gets a known value before any frame is compared
	task automatic clear_screen();
		for (int i = 0; i < 2100; i++) begin
			type_key("clear", 8'h29, 1'b0);
		end
	endtask

	task automatic test_glyphs();
		type_key("glyphs a", 8'h1c, 1'b0);
		type_key("glyphs 1", 8'h16, 1'b0);
		type_key("glyphs space", 8'h29, 1'b0);
		compare_frame("glyphs");
	endtask

	task automatic test_prefixes();
		type_key("prefix break", 8'hf0, 1'b0);
		type_key("prefix break a", 8'h1c, 1'b0);
		type_key("prefix ext", 8'he0, 1'b0);
		type_key("prefix ext up", 8'h75, 1'b0);
		type_key("prefix ext again", 8'he0, 1'b0);
		type_key("prefix ext a", 8'h1c, 1'b0);
		compare_frame("prefixes");
	endtask

	task automatic test_enter_backspace();
		logic [7:0] letters [5];
		letters = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h24};
		type_key("enter", 8'h5a, 1'b0);
		type_key("enter b", 8'h32, 1'b0);
		compare_frame("enter");
		type_key("backspace", 8'h66, 1'b0);
		compare_frame("backspace");
		for (int i = 0; i < 71; i++) begin
			type_key("wrap letter", letters[i % 5], 1'b0);
		end
		compare_frame("wrap");
	endtask

	task automatic test_parity();
		type_key("parity bad", 8'h21, 1'b1);
		type_key("parity good", 8'h23, 1'b0);
		compare_frame("parity");
	endtask

	task automatic test_blanking();
		int n;
		int seen;
		seen = 0;
		cycles_until(sel_vsync, 1'b0, frame_cycles + 1000, n);
		for (int i = 0; i < frame_cycles; i++) begin
			@(negedge clk);
			if (!blank_n) begin
				check_rgb("blanking", '0, rgb);
			end else begin
				seen++;
			end
		end
		check_count("blanking visible pixels", 640 * 480, seen);
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		font_wr = '0;
		rng_state = 32'h71ba161a;
		cur_col = 0;
		cur_row = 0;
		brk_seen = 1'b0;
		ext_seen = 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_bit("reset hsync", 1'b1, hsync);
		check_bit("reset vsync", 1'b1, vsync);
		check_bit("reset blank_n", 1'b0, blank_n);
		check_bit("reset frame_error", 1'b0, frame_error);
		@(posedge clk);
		arst_n <= 1'b1;
		test_raster();
		load_font();
		clear_screen();
		test_glyphs();
		test_prefixes();
		test_enter_backspace();
		test_parity();
		test_blanking();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

//--- src/vga_text_top.sv
`timescale 1ns/100ps

module vga_text_top #(
	parameter vga_text_pkg::rgb_t fg_color = '{r: 8'hff, g: 8'hff, b: 8'hff},
	parameter vga_text_pkg::rgb_t bg_color = '{r: 8'h00, g: 8'h00, b: 8'h00}
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      ps2_clk,
	input  logic                      ps2_data,
	input  vga_text_pkg::font_write_t font_wr,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      blank_n,
	output vga_text_pkg::rgb_t        rgb,
	output logic                      frame_error
);

	vga_text_pkg::vga_timing_t timing;
	vga_text_pkg::char_write_t wr;
	logic [7:0]                code;
	logic                      code_valid;

	vga_timing u_timing (
		.clk    (clk),
		.arst_n (arst_n),
		.timing (timing)
	);

	ps2_receiver u_ps2 (
		.clk         (clk),
		.arst_n      (arst_n),
		.ps2_clk     (ps2_clk),
		.ps2_data    (ps2_data),
		.code        (code),
		.code_valid  (code_valid),
		.frame_error (frame_error)
	);

	key_writer u_keys (
		.clk        (clk),
		.arst_n     (arst_n),
		.code       (code),
		.code_valid (code_valid),
		.wr         (wr)
	);

	// two cycles from timing to pixel
	glyph_renderer #(
		.fg_color (fg_color),
		.bg_color (bg_color)
	) u_render (
		.clk     (clk),
		.arst_n  (arst_n),
		.timing  (timing),
		.wr      (wr),
		.font_wr (font_wr),
		.hsync   (hsync),
		.vsync   (vsync),
		.blank_n (blank_n),
		.rgb     (rgb)
	);

endmodule

//--- src/glyph_renderer.sv
`timescale 1ns/100ps

module glyph_renderer #(
	parameter vga_text_pkg::rgb_t fg_color = '{r: 8'hff, g: 8'hff, b: 8'hff},
	parameter vga_text_pkg::rgb_t bg_color = '{r: 8'h00, g: 8'h00, b: 8'h00}
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  vga_text_pkg::vga_timing_t timing,
	input  vga_text_pkg::char_write_t wr,
	input  vga_text_pkg::font_write_t font_wr,
	output logic                      hsync,
	output logic                      vsync,
	output logic                      blank_n,
	output vga_text_pkg::rgb_t        rgb
);

	localparam int unsigned cells      = vga_text_pkg::text_cols * vga_text_pkg::text_rows;
	localparam int unsigned font_lines = vga_text_pkg::font_glyphs * vga_text_pkg::cell_h;

	// timing carried alongside the buffer read
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       active;
		logic       in_text;
		logic [3:0] cx;
		logic [3:0] cy;
	} stage_t;

	logic [7:0] char_buf [cells];
	logic [7:0] font_ram [font_lines];
	stage_t     s1;
	logic [7:0] s1_char;
	logic       in_text;
	logic [7:0] font_row;
	logic       glyph_bit;

	function automatic logic [11:0] cell_addr(input logic [4:0] row, input logic [6:0] col);
		return 12'(row) * 12'(vga_text_pkg::text_cols) + 12'(col);
	endfunction

	assign in_text = (timing.pos.col < vga_text_pkg::text_cols) &&
		(timing.pos.row < vga_text_pkg::text_rows);

	always_ff @(posedge clk) begin
		if (wr.valid) begin
			char_buf[cell_addr(wr.row, wr.col)] <= wr.ascii;
		end
		if (font_wr.valid) begin
			font_ram[{font_wr.code, font_wr.line}] <= font_wr.bits;
		end
	end

	// stage 1 buffer read
	always_ff @(posedge clk) begin
		if (in_text) begin
			s1_char <= char_buf[cell_addr(timing.pos.row, timing.pos.col)];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1 <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, in_text: 1'b0, cx: '0, cy: '0};
		end else begin
			s1 <= '{hsync: timing.hsync, vsync: timing.vsync, active: timing.active,
				in_text: in_text, cx: timing.pos.cx, cy: timing.pos.cy};
		end
	end

	// stage 2 font lookup, ninth column always blank
	assign font_row  = font_ram[{s1_char[6:0], s1.cy}];
	assign glyph_bit = s1.in_text && !s1_char[7] &&
		(s1.cx < 4'(vga_text_pkg::cell_w - 1)) && font_row[3'd7 - s1.cx[2:0]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hsync   <= 1'b1;
			vsync   <= 1'b1;
			blank_n <= 1'b0;
			rgb     <= '0;
		end else begin
			hsync   <= s1.hsync;
			vsync   <= s1.vsync;
			blank_n <= s1.active;
			if (!s1.active) begin
				rgb <= '0;
			end else if (glyph_bit) begin
				rgb <= fg_color;
			end else begin
				rgb <= bg_color;
			end
		end
	end

endmodule

//--- src/key_writer.sv
`timescale 1ns/100ps

module key_writer (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic [7:0]                code,
	input  logic                      code_valid,
	output vga_text_pkg::char_write_t wr
);

	logic       brk;
	logic       ext;
	logic [6:0] cur_col;
	logic [4:0] cur_row;
	logic [7:0] ascii;
	logic       last_col;
	logic       at_home;
	logic [4:0] row_down;
	logic [6:0] back_col;
	logic [4:0] back_row;

	// set 2 make codes, lower case only
	function automatic logic [7:0] scan_to_ascii(input logic [7:0] sc);
		case (sc)
			8'h1c: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2b: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3b: return "j";
			8'h42: return "k";
			8'h4b: return "l";
			8'h3a: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4d: return "p";
			8'h15: return "q";
			8'h2d: return "r";
			8'h1b: return "s";
			8'h2c: return "t";
			8'h3c: return "u";
			8'h2a: return "v";
			8'h1d: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1a: return "z";
			8'h45: return "0";
			8'h16: return "1";
			8'h1e: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2e: return "5";
			8'h36: return "6";
			8'h3d: return "7";
			8'h3e: return "8";
			8'h46: return "9";
			8'h29: return " ";
			default: return 8'h00;
		endcase
	endfunction

	assign ascii    = scan_to_ascii(code);
	assign last_col = (cur_col == 7'(vga_text_pkg::text_cols - 1));
	assign at_home  = (cur_col == 7'd0) && (cur_row == 5'd0);
	assign row_down = (cur_row == 5'(vga_text_pkg::text_rows - 1)) ? 5'd0 : cur_row + 5'd1;
	assign back_col = (cur_col == 7'd0) ? 7'(vga_text_pkg::text_cols - 1) : cur_col - 7'd1;
	assign back_row = (cur_col == 7'd0) ? cur_row - 5'd1 : cur_row;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			brk     <= 1'b0;
			ext     <= 1'b0;
			cur_col <= '0;
			cur_row <= '0;
			wr      <= '0;
		end else begin
			wr.valid <= 1'b0;
			if (code_valid) begin
				if (code == 8'hf0) begin
					brk <= 1'b1;
				end else if (code == 8'he0) begin
					ext <= 1'b1;
				end else if (brk || ext) begin
					// code after a prefix is dropped
					brk <= 1'b0;
					ext <= 1'b0;
				end else if (code == 8'h5a) begin
					cur_col <= '0;
					cur_row <= row_down;
				end else if (code == 8'h66) begin
					if (!at_home) begin
						cur_col <= back_col;
						cur_row <= back_row;
						wr      <= '{valid: 1'b1, col: back_col, row: back_row, ascii: " "};
					end
				end else if (ascii != 8'h00) begin
					wr      <= '{valid: 1'b1, col: cur_col, row: cur_row, ascii: ascii};
					cur_col <= last_col ? 7'd0 : cur_col + 7'd1;
					if (last_col) begin
						cur_row <= row_down;
					end
				end
			end
		end
	end

	a_wr_in_grid: assert property (@(posedge clk) disable iff (!arst_n)
		wr.valid |-> (wr.col < vga_text_pkg::text_cols && wr.row < vga_text_pkg::text_rows));

endmodule

//--- src/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] code,
	output logic       code_valid,
	output logic       frame_error
);

	localparam int unsigned idle_limit = 2000;

	logic [2:0]  clk_sync;
	logic [2:0]  data_sync;
	logic        clk_prev;
	logic        fall;
	logic [9:0]  shift;
	logic [3:0]  bit_cnt;
	logic [10:0] idle_cnt;
	logic        idle_timeout;
	logic        frame_ok;

	// both lines idle high
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			clk_sync  <= '1;
			data_sync <= '1;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[1:0], ps2_clk};
			data_sync <= {data_sync[1:0], ps2_data};
			clk_prev  <= clk_sync[2];
		end
	end

	assign fall = clk_prev && !clk_sync[2];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			idle_cnt <= '0;
		end else if (!clk_sync[2]) begin
			idle_cnt <= '0;
		end else if (!idle_timeout) begin
			idle_cnt <= idle_cnt + 11'd1;
		end
	end

	assign idle_timeout = (idle_cnt == 11'(idle_limit - 1));

	// shift holds start, data and parity; the stop bit is still on the line
	assign frame_ok = !shift[0] && data_sync[2] && (^shift[9:1]);

	always_ff @(posedge clk) begin
		if (fall && bit_cnt != 4'd10) begin
			shift <= {data_sync[2], shift[9:1]};
		end
		if (fall && bit_cnt == 4'd10 && frame_ok) begin
			code <= shift[8:1];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt     <= '0;
			code_valid  <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			code_valid  <= 1'b0;
			frame_error <= 1'b0;
			if (fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt     <= '0;
					code_valid  <= frame_ok;
					frame_error <= !frame_ok;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (idle_timeout) begin
				// stale partial frame
				bit_cnt <= '0;
			end
		end
	end

	a_one_outcome: assert property (@(posedge clk) disable iff (!arst_n)
		!(code_valid && frame_error));

endmodule

//--- src/vga_timing.sv
`timescale 1ns/100ps

module vga_timing (
	input  logic                      clk,
	input  logic                      arst_n,
	output vga_text_pkg::vga_timing_t timing
);

	localparam logic [9:0] hs_start = vga_text_pkg::h_visible + vga_text_pkg::h_front;
	localparam logic [9:0] hs_end   = hs_start + vga_text_pkg::h_sync;
	localparam logic [9:0] vs_start = vga_text_pkg::v_visible + vga_text_pkg::v_front;
	localparam logic [9:0] vs_end   = vs_start + vga_text_pkg::v_sync;

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;
	logic [6:0] col;
	logic [3:0] cx;
	logic [4:0] row;
	logic [3:0] cy;
	logic       line_end;
	logic       frame_end;

	assign line_end  = (h_cnt == vga_text_pkg::h_total - 10'd1);
	assign frame_end = (v_cnt == vga_text_pkg::v_total - 10'd1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			v_cnt <= frame_end ? 10'd0 : v_cnt + 10'd1;
		end else begin
			h_cnt <= h_cnt + 10'd1;
		end
	end

	// cell counters stop once past the visible width
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col <= '0;
			cx  <= '0;
		end else if (line_end) begin
			col <= '0;
			cx  <= '0;
		end else if (h_cnt < vga_text_pkg::h_visible) begin
			if (cx == 4'(vga_text_pkg::cell_w - 1)) begin
				cx  <= '0;
				col <= col + 7'd1;
			end else begin
				cx <= cx + 4'd1;
			end
		end
	end

	// row advances at line end and holds during vertical blanking
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			row <= '0;
			cy  <= '0;
		end else if (line_end) begin
			if (frame_end) begin
				row <= '0;
				cy  <= '0;
			end else if (v_cnt < vga_text_pkg::v_visible) begin
				if (cy == 4'(vga_text_pkg::cell_h - 1)) begin
					cy  <= '0;
					row <= row + 5'd1;
				end else begin
					cy <= cy + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			timing <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0, pos: '0};
		end else begin
			timing.hsync  <= !(h_cnt >= hs_start && h_cnt < hs_end);
			timing.vsync  <= !(v_cnt >= vs_start && v_cnt < vs_end);
			timing.active <= (h_cnt < vga_text_pkg::h_visible) &&
				(v_cnt < vga_text_pkg::v_visible);
			timing.pos    <= '{col: col, cx: cx, row: row, cy: cy};
		end
	end

	// hsync pulse only in the blanking interval
	a_hsync_window: assert property (@(posedge clk) disable iff (!arst_n)
		!timing.hsync |-> !timing.active);

endmodule

//--- src/vga_text_pkg.sv
package vga_text_pkg;

	// 640x480 at 60 Hz, counts in pixel clocks and lines
	localparam logic [9:0] h_visible = 10'd640;
	localparam logic [9:0] h_front   = 10'd16;
	localparam logic [9:0] h_sync    = 10'd96;
	localparam logic [9:0] h_back    = 10'd48;
	localparam logic [9:0] h_total   = 10'd800;

	localparam logic [9:0] v_visible = 10'd480;
	localparam logic [9:0] v_front   = 10'd10;
	localparam logic [9:0] v_sync    = 10'd2;
	localparam logic [9:0] v_back    = 10'd33;
	localparam logic [9:0] v_total   = 10'd525;

	// text grid
	localparam int unsigned text_cols   = 70;
	localparam int unsigned text_rows   = 30;
	localparam int unsigned cell_w      = 9;
	localparam int unsigned cell_h      = 16;
	localparam int unsigned font_glyphs = 128;

	typedef struct packed {
		logic [6:0] col;
		logic [3:0] cx;
		logic [4:0] row;
		logic [3:0] cy;
	} cell_pos_t;

	typedef struct packed {
		logic      hsync;
		logic      vsync;
		logic      active;
		cell_pos_t pos;
	} vga_timing_t;

	typedef struct packed {
		logic       valid;
		logic [6:0] col;
		logic [4:0] row;
		logic [7:0] ascii;
	} char_write_t;

	// bits[7] is the leftmost pixel of the glyph line
	typedef struct packed {
		logic       valid;
		logic [6:0] code;
		logic [3:0] line;
		logic [7:0] bits;
	} font_write_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

endpackage
